// ==== include/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data path width
`define CSR_XLEN 32

// MXL = 1, I extension only
`define CSR_MISA_RESET 32'h4000_0100

// Write masks, a set bit is software writable
`define CSR_WMASK_MSTATUS 32'h0000_1888  // MIE, MPIE, MPP
`define CSR_WMASK_MIE     32'h0000_0888  // MSIE, MTIE, MEIE
`define CSR_WMASK_MTVEC   32'hFFFF_FFFC  // Direct mode only
`define CSR_WMASK_MEPC    32'hFFFF_FFFC

// mstatus fields
`define CSR_MIE_BIT  3
`define CSR_MPIE_BIT 7
`define CSR_MPP_LSB  11
`define CSR_MPP_MSB  12

// Interrupt line positions in mip and mie
`define CSR_IRQ_MSI 3
`define CSR_IRQ_MTI 7
`define CSR_IRQ_MEI 11

`endif

// ==== src/csr_pkg.sv ====
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    typedef enum logic [11:0] {
        MSTATUS   = 12'h300,
        MISA      = 12'h301,
        MIE       = 12'h304,
        MTVEC     = 12'h305,
        MSCRATCH  = 12'h340,
        MEPC      = 12'h341,
        MCAUSE    = 12'h342,
        MTVAL     = 12'h343,
        MIP       = 12'h344,
        MCYCLE    = 12'hB00,
        MINSTRET  = 12'hB02,
        MCYCLEH   = 12'hB80,
        MINSTRETH = 12'hB82,
        CYCLE     = 12'hC00,  // User counters, read only
        TIME      = 12'hC01,
        INSTRET   = 12'hC02,
        CYCLEH    = 12'hC80,
        TIMEH     = 12'hC81,
        INSTRETH  = 12'hC82,
        MVENDORID = 12'hF11,  // Identity, read as zero
        MARCHID   = 12'hF12,
        MIMPID    = 12'hF13,
        MHARTID   = 12'hF14
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [4:0] {
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_LOAD_MISALIGNED  = 5'd4,
        EXC_STORE_MISALIGNED = 5'd6,
        EXC_ECALL_M          = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_M_SW    = 5'd3,
        IRQ_M_TIMER = 5'd7,
        IRQ_M_EXT   = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_e;

    // Decoder to bank
    typedef struct packed {
        logic                 re;
        logic                 we;
        csr_op_e              op;
        csr_addr_e            addr;
        logic [`CSR_XLEN-1:0] data;
    } csr_req_t;

    // Trap and return controls from the pipeline
    typedef struct packed {
        logic                 raise_exception;
        exc_code_e            exc_code;
        logic                 mret;
        logic                 interrupt_ack;
        logic [`CSR_XLEN-1:0] pc;
        logic [`CSR_XLEN-1:0] instr;
        logic                 jump;
        logic [`CSR_XLEN-1:0] jump_target;
    } trap_req_t;

endpackage

`default_nettype wire

// ==== src/csr_instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_instr_decode (
    input  logic [31:0]        instr_i,
    input  logic [31:0]        rs1_data_i,
    input  logic               valid_i,
    output csr_pkg::csr_req_t  req_o,
    output logic               illegal_o
);
    import csr_pkg::*;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b111_0011;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs1;       // Also the zimm field
    logic [11:0] csr_field;
    logic        is_csr;
    logic        read_only;

    assign opcode    = instr_i[6:0];
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1       = instr_i[19:15];
    assign csr_field = instr_i[31:20];

    // funct3 of 000 and 100 are not CSR accesses
    assign is_csr    = (opcode == OPCODE_SYSTEM) && (funct3[1:0] != 2'b00);
    assign read_only = &csr_field[11:10];

    always_comb begin
        req_o     = '0;
        illegal_o = 1'b0;
        if (valid_i && is_csr) begin
            req_o.addr = csr_addr_e'(csr_field);
            req_o.data = funct3[2] ? {{(`CSR_XLEN-5){1'b0}}, rs1} : rs1_data_i;
            case (funct3[1:0])
                2'b01: begin
                    req_o.op = CSR_WRITE;
                    req_o.re = (rd != 5'd0);  // CSRRW x0 skips the read
                    req_o.we = 1'b1;
                end
                2'b10: begin
                    req_o.op = CSR_SET;
                    req_o.re = 1'b1;
                    req_o.we = (rs1 != 5'd0);
                end
                default: begin
                    req_o.op = CSR_CLEAR;
                    req_o.re = 1'b1;
                    req_o.we = (rs1 != 5'd0);
                end
            endcase

            // Read-only space takes no write
            if (req_o.we && read_only) begin
                illegal_o = 1'b1;
                req_o.we  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/csr_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_bank (
    input  logic                 clk,
    input  logic                 reset,
    input  csr_pkg::csr_req_t    req_i,
    input  logic                 killed_i,
    input  csr_pkg::trap_req_t   trap_i,
    input  logic [63:0]          mtime_i,
    input  logic [31:0]          irq_i,
    output logic [31:0]          rd_data_o,
    output logic [31:0]          mtvec_o,
    output logic [31:0]          mepc_o,
    output csr_pkg::priv_e       priv_o,
    output logic                 irq_pending_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec_q;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc_q;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mip;
    logic [63:0]          mcycle;
    logic [63:0]          minstret;
    priv_e                priv_q;
    irq_code_e            irq_code_q;  // Cause latched with the pending flag

    logic [`CSR_XLEN-1:0] cur_val;
    logic [`CSR_XLEN-1:0] wmask;
    logic [`CSR_XLEN-1:0] wr_data;
    logic                 trap_enter;
    logic                 irq_enabled;

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;
    assign priv_o  = priv_q;

    assign trap_enter  = trap_i.raise_exception || trap_i.interrupt_ack;
    assign irq_enabled = mstatus[`CSR_MIE_BIT] && ((mie & mip) != '0);

    // Current value of the addressed register
    always_comb begin
        case (req_i.addr)
            MSTATUS:   cur_val = mstatus;
            MIE:       cur_val = mie;
            MTVEC:     cur_val = mtvec_q;
            MEPC:      cur_val = mepc_q;
            MSCRATCH:  cur_val = mscratch;
            MCAUSE:    cur_val = mcause;
            MTVAL:     cur_val = mtval;
            MCYCLE:    cur_val = mcycle[31:0];
            MCYCLEH:   cur_val = mcycle[63:32];
            MINSTRET:  cur_val = minstret[31:0];
            MINSTRETH: cur_val = minstret[63:32];
            default:   cur_val = '0;
        endcase
    end

    // Write mask of the addressed register
    always_comb begin
        case (req_i.addr)
            MSTATUS:   wmask = `CSR_WMASK_MSTATUS;
            MIE:       wmask = `CSR_WMASK_MIE;
            MTVEC:     wmask = `CSR_WMASK_MTVEC;
            MEPC:      wmask = `CSR_WMASK_MEPC;
            MSCRATCH,
            MCAUSE,
            MTVAL,
            MCYCLE,
            MCYCLEH,
            MINSTRET,
            MINSTRETH: wmask = '1;
            default:   wmask = '0;  // No entry means writes are ignored
        endcase
    end

    always_comb begin
        case (req_i.op)
            CSR_WRITE: wr_data = req_i.data & wmask;
            CSR_SET:   wr_data = (cur_val | req_i.data) & wmask;
            CSR_CLEAR: wr_data = (cur_val & ~req_i.data) & wmask;
            default:   wr_data = cur_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec_q  <= '0;
            mscratch <= '0;
            mepc_q   <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mcycle   <= '0;
            minstret <= '0;
            priv_q   <= PRIV_MACHINE;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (!killed_i) begin
                minstret <= minstret + 64'd1;
            end

            if (trap_i.mret) begin
                mstatus[`CSR_MIE_BIT] <= mstatus[`CSR_MPIE_BIT];
                priv_q <= priv_e'(mstatus[`CSR_MPP_MSB:`CSR_MPP_LSB]);
            end else if (trap_enter) begin
                mstatus[`CSR_MPIE_BIT] <= mstatus[`CSR_MIE_BIT];
                mstatus[`CSR_MIE_BIT]  <= 1'b0;
                mstatus[`CSR_MPP_MSB:`CSR_MPP_LSB] <= priv_q;
                priv_q <= PRIV_MACHINE;
                if (trap_i.raise_exception) begin
                    mcause <= {27'b0, trap_i.exc_code};
                    // ecall and ebreak return to the trapping instruction
                    if (trap_i.exc_code == EXC_ECALL_M || trap_i.exc_code == EXC_BREAKPOINT)
                        mepc_q <= trap_i.pc;
                    else
                        mepc_q <= trap_i.pc + 32'd4;
                    mtval <= (trap_i.exc_code == EXC_ILLEGAL_INSTR) ? trap_i.instr : trap_i.pc;
                end else begin
                    mcause <= {1'b1, 26'b0, irq_code_q};
                    mepc_q <= trap_i.jump ? trap_i.jump_target : trap_i.pc;
                end
            end else if (req_i.we && !killed_i) begin
                case (req_i.addr)
                    MSTATUS:   mstatus         <= wr_data;
                    MIE:       mie             <= wr_data;
                    MTVEC:     mtvec_q         <= wr_data;
                    MSCRATCH:  mscratch        <= wr_data;
                    MEPC:      mepc_q          <= wr_data;
                    MCAUSE:    mcause          <= wr_data;
                    MTVAL:     mtval           <= wr_data;
                    MCYCLE:    mcycle[31:0]    <= wr_data;  // Overrides the increment
                    MCYCLEH:   mcycle[63:32]   <= wr_data;
                    MINSTRET:  minstret[31:0]  <= wr_data;
                    MINSTRETH: minstret[63:32] <= wr_data;
                    default: ;
                endcase
            end
        end
    end

    // Read port gives zero for squashed or absent reads
    always_comb begin
        rd_data_o = '0;
        if (req_i.re && !killed_i) begin
            case (req_i.addr)
                MSTATUS:   rd_data_o = mstatus;
                MISA:      rd_data_o = `CSR_MISA_RESET;
                MIE:       rd_data_o = mie;
                MTVEC:     rd_data_o = mtvec_q;
                MSCRATCH:  rd_data_o = mscratch;
                MEPC:      rd_data_o = mepc_q;
                MCAUSE:    rd_data_o = mcause;
                MTVAL:     rd_data_o = mtval;
                MIP:       rd_data_o = mip;
                MCYCLE,
                CYCLE:     rd_data_o = mcycle[31:0];
                MCYCLEH,
                CYCLEH:    rd_data_o = mcycle[63:32];
                MINSTRET,
                INSTRET:   rd_data_o = minstret[31:0];
                MINSTRETH,
                INSTRETH:  rd_data_o = minstret[63:32];
                TIME:      rd_data_o = mtime_i[31:0];
                TIMEH:     rd_data_o = mtime_i[63:32];
                default:   rd_data_o = '0;  // Identity registers included
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mip           <= '0;
            irq_pending_o <= 1'b0;
        end else begin
            mip           <= irq_i;
            irq_pending_o <= irq_enabled && !trap_i.interrupt_ack;
        end
    end

    // External first, then software, then timer
    always_ff @(posedge clk) begin
        if (irq_enabled && !trap_i.interrupt_ack) begin
            if (mip[`CSR_IRQ_MEI] && mie[`CSR_IRQ_MEI])
                irq_code_q <= IRQ_M_EXT;
            else if (mip[`CSR_IRQ_MSI] && mie[`CSR_IRQ_MSI])
                irq_code_q <= IRQ_M_SW;
            else
                irq_code_q <= IRQ_M_TIMER;
        end
    end

endmodule

`default_nettype wire

// ==== src/machine_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module machine_timer (
    input  logic        clk,
    input  logic        reset,
    input  logic        mtimecmp_we_i,
    input  logic [63:0] mtimecmp_data_i,
    output logic [63:0] mtime_o,
    output logic        timer_irq_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;

    // Free-running, one tick per clock
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp_q <= '1;  // Keeps the irq quiet after reset
        end else if (mtimecmp_we_i) begin
            mtimecmp_q <= mtimecmp_data_i;
        end
    end

    assign mtime_o = mtime_q;

    // Level stays up until software moves the compare value
    assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

`default_nettype wire

// ==== src/csr_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module csr_subsystem (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [31:0]          instr_i,
    input  logic [31:0]          rs1_data_i,
    input  logic                 valid_i,
    input  logic                 killed_i,
    input  csr_pkg::trap_req_t   trap_i,
    input  logic                 irq_ext_i,
    input  logic                 irq_sw_i,
    input  logic                 mtimecmp_we_i,
    input  logic [63:0]          mtimecmp_data_i,
    output logic [31:0]          rd_data_o,
    output logic                 illegal_o,
    output logic [31:0]          mtvec_o,
    output logic [31:0]          mepc_o,
    output csr_pkg::priv_e       priv_o,
    output logic                 irq_pending_o
);
    import csr_pkg::*;

    csr_req_t    csr_req;
    logic [63:0] mtime;
    logic        timer_irq;
    logic [31:0] irq_vec;

    // Standard machine interrupt positions
    always_comb begin
        irq_vec              = '0;
        irq_vec[`CSR_IRQ_MSI] = irq_sw_i;
        irq_vec[`CSR_IRQ_MTI] = timer_irq;
        irq_vec[`CSR_IRQ_MEI] = irq_ext_i;
    end

    csr_instr_decode u_decode (
        .instr_i    (instr_i),
        .rs1_data_i (rs1_data_i),
        .valid_i    (valid_i),
        .req_o      (csr_req),
        .illegal_o  (illegal_o)
    );

    csr_bank u_bank (
        .clk           (clk),
        .reset         (reset),
        .req_i         (csr_req),
        .killed_i      (killed_i),
        .trap_i        (trap_i),
        .mtime_i       (mtime),
        .irq_i         (irq_vec),
        .rd_data_o     (rd_data_o),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o),
        .priv_o        (priv_o),
        .irq_pending_o (irq_pending_o)
    );

    machine_timer u_timer (
        .clk             (clk),
        .reset           (reset),
        .mtimecmp_we_i   (mtimecmp_we_i),
        .mtimecmp_data_i (mtimecmp_data_i),
        .mtime_o         (mtime),
        .timer_irq_o     (timer_irq)
    );

endmodule

`default_nettype wire

// ==== tb/csr_subsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_subsystem_assert (
    input logic               clk,
    input logic               reset,
    input csr_pkg::trap_req_t trap_i,
    input logic               killed_i,
    input logic [31:0]        rd_data_i,
    input csr_pkg::priv_e     priv_i,
    input logic               irq_pending_i
);
    import csr_pkg::*;

    logic trap_entry;

    assign trap_entry = (trap_i.raise_exception || trap_i.interrupt_ack) && !trap_i.mret;

    ack_clears_pending: assert property (
        @(posedge clk) disable iff (reset)
        trap_i.interrupt_ack |=> !irq_pending_i
    ) else $error("irq_pending high in the cycle after an interrupt ack");

    // Any trap entry lands in machine mode
    trap_to_machine: assert property (
        @(posedge clk) disable iff (reset)
        trap_entry |=> (priv_i == PRIV_MACHINE)
    ) else $error("priv is not machine after a trap entry");

    killed_reads_zero: assert property (
        @(posedge clk) disable iff (reset)
        killed_i |-> (rd_data_i == '0)
    ) else $error("rd_data nonzero while killed is high");

endmodule

bind csr_bank csr_subsystem_assert i_assert (
    .clk           (clk),
    .reset         (reset),
    .trap_i        (trap_i),
    .killed_i      (killed_i),
    .rd_data_i     (rd_data_o),
    .priv_i        (priv_o),
    .irq_pending_i (irq_pending_o)
);

`default_nettype wire

// ==== tb/tb_csr_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "csr_consts.svh"

module tb_csr_subsystem;
    import csr_pkg::*;

    localparam logic [2:0] F3_RW  = 3'b001;
    localparam logic [2:0] F3_RS  = 3'b010;
    localparam logic [2:0] F3_RC  = 3'b011;
    localparam logic [2:0] F3_RSI = 3'b110;
    localparam logic [2:0] F3_RCI = 3'b111;
    localparam int PHASE_CYCLES   = 60;  // Trap, interrupt, timer and counter phases

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] rs1_data;
        logic        killed;
        logic [31:0] exp_rd;
        logic        exp_illegal;
    } row_t;

    logic        clk;
    logic        reset;
    logic [31:0] instr_i;
    logic [31:0] rs1_data_i;
    logic        valid_i;
    logic        killed_i;
    trap_req_t   trap_i;
    logic        irq_ext_i;
    logic        irq_sw_i;
    logic        mtimecmp_we_i;
    logic [63:0] mtimecmp_data_i;
    logic [31:0] rd_data_o;
    logic        illegal_o;
    logic [31:0] mtvec_o;
    logic [31:0] mepc_o;
    priv_e       priv_o;
    logic        irq_pending_o;

    row_t        rows[$];
    logic [31:0] mirror [4096];  // Expected CSR contents
    logic [31:0] wmask [4096];
    logic [31:0] lcg_state;
    int          cycles = 0;
    int          limit;
    int          err_count = 0;

    csr_subsystem i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            abort_run($sformatf("timeout: the run did not end within %0d cycles", limit));
        end
    end

    task automatic abort_run(input string why);
        err_count++;
        $display("%s", why);
        $display("test failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_priv(input string name, input priv_e got, input priv_e exp);
        if (got !== exp) begin
            abort_run($sformatf("error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [4:0] rs1, input csr_addr_e addr);
        return {addr, rs1, f3, rd, 7'b111_0011};  // SYSTEM opcode
    endfunction

    // Expected read is the old value and the mirror takes the masked result
    task automatic add_row(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input csr_addr_e addr, input logic [31:0] data, input logic kill);
        row_t        r;
        logic [31:0] cur;
        logic [31:0] opnd;
        logic [31:0] nxt;
        logic        wr;
        cur  = mirror[addr];
        opnd = f3[2] ? {27'b0, rs1} : data;
        wr   = (f3[1:0] == 2'b01) || (rs1 != 5'd0);
        r.instr       = csr_instr(f3, rd, rs1, addr);
        r.rs1_data    = data;
        r.killed      = kill;
        r.exp_illegal = wr && (addr[11:10] == 2'b11);
        r.exp_rd      = (kill || (f3[1:0] == 2'b01 && rd == 5'd0)) ? 32'd0 : cur;
        case (f3[1:0])
            2'b01:   nxt = opnd;
            2'b10:   nxt = cur | opnd;
            default: nxt = cur & ~opnd;
        endcase
        if (wr && !r.exp_illegal && !kill) begin
            mirror[addr] = (nxt & wmask[addr]) | (cur & ~wmask[addr]);
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        lcg_state = 32'd91886;
        for (int a = 0; a < 4096; a++) begin
            mirror[a[11:0]] = '0;
            wmask[a[11:0]]  = '0;
        end
        mirror[MISA]    = `CSR_MISA_RESET;
        wmask[MSCRATCH] = '1;
        wmask[MTVEC]    = `CSR_WMASK_MTVEC;
        wmask[MIE]      = `CSR_WMASK_MIE;
        repeat (3) begin
            add_row(F3_RW, 5'd1, 5'd5, MSCRATCH, lcg_next(), 1'b0);
            add_row(F3_RS, 5'd1, 5'd6, MSCRATCH, lcg_next(), 1'b0);
            add_row(F3_RC, 5'd1, 5'd7, MSCRATCH, lcg_next(), 1'b0);
        end
        add_row(F3_RS, 5'd1, 5'd0, MSCRATCH, lcg_next(), 1'b0);  // x0 source makes no write
        add_row(F3_RS, 5'd1, 5'd0, MSCRATCH, 32'd0, 1'b0);
        add_row(F3_RW, 5'd1, 5'd5, MTVEC, lcg_next(), 1'b0);
        add_row(F3_RSI, 5'd1, 5'd3, MTVEC, 32'd0, 1'b0);  // Mode bits stay clear
        add_row(F3_RS, 5'd1, 5'd0, MTVEC, 32'd0, 1'b0);
        add_row(F3_RW, 5'd1, 5'd5, MIE, 32'hFFFF_FFFF, 1'b0);
        add_row(F3_RCI, 5'd1, 5'd8, MIE, 32'd0, 1'b0);
        add_row(F3_RS, 5'd1, 5'd0, MIE, 32'd0, 1'b0);
        add_row(F3_RW, 5'd1, 5'd5, MISA, 32'd0, 1'b0);
        add_row(F3_RS, 5'd1, 5'd0, MISA, 32'd0, 1'b0);
        add_row(F3_RW, 5'd1, 5'd5, MHARTID, lcg_next(), 1'b0);  // Read-only space
        add_row(F3_RS, 5'd1, 5'd0, MHARTID, 32'd0, 1'b0);
        add_row(F3_RW, 5'd1, 5'd5, MSCRATCH, lcg_next(), 1'b1);  // Squashed
        add_row(F3_RS, 5'd1, 5'd0, MSCRATCH, 32'd0, 1'b0);
        add_row(F3_RW, 5'd0, 5'd5, MIE, 32'd0, 1'b0);  // x0 destination skips the read
        add_row(F3_RS, 5'd1, 5'd0, MIE, 32'd0, 1'b0);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
        instr_i    = csr_instr(F3_RW, 5'd0, 5'd5, addr);
        rs1_data_i = data;
        valid_i    = 1'b1;
        next_cycle();
        valid_i    = 1'b0;
    endtask

    task automatic sample_csr(input csr_addr_e addr, output logic [31:0] val, output int at);
        instr_i = csr_instr(F3_RS, 5'd1, 5'd0, addr);
        valid_i = 1'b1;
        #5;
        val = rd_data_o;
        at  = cycles;
        next_cycle();
        valid_i = 1'b0;
    endtask

    task automatic read_csr(input string name, input csr_addr_e addr, input logic [31:0] exp);
        logic [31:0] val;
        int          at;
        sample_csr(addr, val, at);
        check_word(name, val, exp);
    endtask

    task automatic pulse_trap(input trap_req_t t);
        trap_i = t;
        next_cycle();
        trap_i = '0;
    endtask

    // Pending flag is registered twice behind the lines
    task automatic wait_pending(input int max_cycles);
        int n;
        n = 0;
        while (irq_pending_o !== 1'b1 && n < max_cycles) begin
            next_cycle();
            n++;
        end
        if (irq_pending_o !== 1'b1) begin
            abort_run($sformatf("irq_pending_o did not rise within %0d cycles", max_cycles));
        end
    endtask

    initial begin
        trap_req_t   t;
        logic [31:0] v1;
        logic [31:0] v2;
        int          c1;
        int          c2;
        reset           = 1'b1;
        instr_i         = '0;
        rs1_data_i      = '0;
        valid_i         = 1'b0;
        killed_i        = 1'b0;
        trap_i          = '0;
        irq_ext_i       = 1'b0;
        irq_sw_i        = 1'b0;
        mtimecmp_we_i   = 1'b0;
        mtimecmp_data_i = '0;
        build_table();
        limit = 2 * rows.size() + 4 + PHASE_CYCLES;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        valid_i = 1'b1;
        foreach (rows[i]) begin
            instr_i    = rows[i].instr;
            rs1_data_i = rows[i].rs1_data;
            killed_i   = rows[i].killed;
            #5;
            check_word("rd_data_o", rd_data_o, rows[i].exp_rd);
            check_bit("illegal_o", illegal_o, rows[i].exp_illegal);
            next_cycle();
        end
        valid_i  = 1'b0;
        killed_i = 1'b0;
        check_word("mtvec_o", mtvec_o, mirror[MTVEC]);

        // MRET with MPP of user drops to user mode
        write_csr(MSTATUS, 32'd1 << `CSR_MIE_BIT);
        t = '0;
        t.mret = 1'b1;
        pulse_trap(t);
        check_priv("priv_o", priv_o, PRIV_USER);
        write_csr(MSTATUS, 32'd1 << `CSR_MIE_BIT);
        t = '0;
        t.raise_exception = 1'b1;
        t.exc_code        = EXC_ECALL_M;
        t.pc              = 32'h0000_1000;
        pulse_trap(t);
        check_word("mepc_o", mepc_o, 32'h0000_1000);
        check_priv("priv_o", priv_o, PRIV_MACHINE);
        read_csr("mcause", MCAUSE, 32'd11);
        read_csr("mstatus", MSTATUS, 32'd1 << `CSR_MPIE_BIT);
        t = '0;
        t.mret = 1'b1;
        pulse_trap(t);
        read_csr("mstatus", MSTATUS, (32'd1 << `CSR_MPIE_BIT) | (32'd1 << `CSR_MIE_BIT));
        check_priv("priv_o", priv_o, PRIV_USER);
        t = '0;
        t.raise_exception = 1'b1;
        t.exc_code        = EXC_ILLEGAL_INSTR;
        t.pc              = 32'h0000_2000;
        t.instr           = 32'hDEAD_BEEF;
        pulse_trap(t);
        check_word("mepc_o", mepc_o, 32'h0000_2004);  // Returns past the bad word
        check_priv("priv_o", priv_o, PRIV_MACHINE);
        read_csr("mtval", MTVAL, 32'hDEAD_BEEF);
        read_csr("mcause", MCAUSE, 32'd2);

        // External interrupt first masked by MIE
        write_csr(MIE, 32'd1 << `CSR_IRQ_MEI);
        irq_ext_i = 1'b1;
        repeat (4) begin
            next_cycle();
            check_bit("irq_pending_o", irq_pending_o, 1'b0);
        end
        irq_ext_i = 1'b0;
        write_csr(MSTATUS, 32'd1 << `CSR_MIE_BIT);
        irq_ext_i = 1'b1;
        wait_pending(2);
        t = '0;
        t.interrupt_ack = 1'b1;
        t.pc            = 32'h0000_3000;
        t.jump          = 1'b1;
        t.jump_target   = 32'h0000_3400;
        irq_ext_i = 1'b0;
        pulse_trap(t);
        check_bit("irq_pending_o", irq_pending_o, 1'b0);
        check_word("mepc_o", mepc_o, 32'h0000_3400);
        read_csr("mcause", MCAUSE, 32'h8000_000B);

        // Timer compare already behind mtime
        mtimecmp_data_i = 64'd16;
        mtimecmp_we_i   = 1'b1;
        next_cycle();
        mtimecmp_we_i   = 1'b0;
        write_csr(MIE, 32'd1 << `CSR_IRQ_MTI);
        write_csr(MSTATUS, 32'd1 << `CSR_MIE_BIT);
        wait_pending(2);
        t = '0;
        t.interrupt_ack = 1'b1;
        t.pc            = 32'h0000_4000;
        pulse_trap(t);
        check_word("mepc_o", mepc_o, 32'h0000_4000);
        read_csr("mcause", MCAUSE, 32'h8000_0007);

        sample_csr(CYCLE, v1, c1);
        repeat (3) next_cycle();
        sample_csr(CYCLE, v2, c2);
        check_word("cycle delta", v2 - v1, 32'(c2 - c1));
        sample_csr(INSTRET, v1, c1);
        killed_i = 1'b1;
        repeat (3) next_cycle();
        killed_i = 1'b0;
        sample_csr(INSTRET, v2, c2);
        check_word("instret delta", v2 - v1, 32'(c2 - c1 - 3));  // Killed cycles not retired

        if (err_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run("checks failed before the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
src/csr_pkg.sv
src/csr_instr_decode.sv
src/csr_bank.sv
src/machine_timer.sv
src/csr_subsystem.sv
tb/csr_subsystem_assert.sv
tb/tb_csr_subsystem.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_csr_subsystem
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
